// ==== all.f ====
+incdir+.
cmdPkg.sv
cmdAssembler.sv
setupRegs.sv
sramSequencer.sv
txSerializer.sv
cmdBridgeTop.sv
cmdBridge_assert.sv
tb_cmdBridge.sv

// ==== cmdAssembler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cmd_macros.svh"

module cmdAssembler (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  cmdPkg::byteT     rxData,
	input  logic             rxReady,
	output cmdPkg::cmdFrameT frame,
	output logic             frameValid
);
	import cmdPkg::*;

	// Frame shift register
	cmdFrameT frameReg;
	// Frame as it stands once the current byte is in
	cmdFrameT nextFrame;
	// Position of the next byte in its frame
	logic [2:0] byteCnt;
	// Current byte closes a frame
	logic lastByte;
	// Legal action and target codes
	logic actionOk;
	logic targetOk;

	//////////////////////////////
	// Byte position
	//////////////////////////////

	assign nextFrame = {frameReg[55:0], rxData};
	assign lastByte = (byteCnt == 3'(`FRAME_BYTES - 1));

	// Counter runs from reset so boundaries never slip
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			byteCnt <= '0;
		else if (rxReady)
		begin
			if (lastByte)
				byteCnt <= '0;
			else
				byteCnt <= byteCnt + 3'd1;
		end
	end

	// Oldest byte falls out at the top
	always_ff @(posedge iCLK)
	begin
		if (rxReady)
			frameReg <= nextFrame;
	end

	//////////////////////////////
	// Frame check
	//////////////////////////////

	assign actionOk = (nextFrame.action == `ACT_READ) ||
		(nextFrame.action == `ACT_WRITE) ||
		(nextFrame.action == `ACT_SETUP);
	assign targetOk = (nextFrame.target == `TGT_SRAM) ||
		(nextFrame.target == `TGT_SETREG);

	// One-cycle strobe alongside the completed frame
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			frameValid <= 1'b0;
		else
			frameValid <= rxReady && lastByte && actionOk && targetOk;
	end

	assign frame = frameReg;

endmodule

`default_nettype wire

// ==== cmdBridgeTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmdBridgeTop (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  cmdPkg::byteT     rxData,
	input  logic             rxReady,
	output cmdPkg::byteT     txData,
	output logic             txStart,
	input  logic             txDone,
	output logic             hold,
	input  logic             hlda,
	output cmdPkg::sramAddrT sramAddr,
	output cmdPkg::sramDataT sramWrData,
	output logic             sramWeN,
	output logic             sramOeN,
	input  cmdPkg::sramDataT sramRdData
);
	import cmdPkg::*;

	//////////////////////////////
	// Internal links
	//////////////////////////////

	// Assembled frame and its strobe
	cmdFrameT frame;
	logic     frameValid;
	// Read-back enable from the setup registers
	logic     readBackEn;
	// Read word handed to the serializer
	sramDataT wordOut;
	logic     wordValid;
	logic     txBusy;

	// Byte link to frames
	cmdAssembler uAssembler (
		.iCLK       (iCLK),
		.iRST_n     (iRST_n),
		.rxData     (rxData),
		.rxReady    (rxReady),
		.frame      (frame),
		.frameValid (frameValid)
	);

	// SETUP frame decode
	setupRegs uSetupRegs (
		.iCLK       (iCLK),
		.iRST_n     (iRST_n),
		.frame      (frame),
		.frameValid (frameValid),
		.readBackEn (readBackEn)
	);

	// Hold exchange and SRAM strobes
	sramSequencer uSequencer (
		.iCLK       (iCLK),
		.iRST_n     (iRST_n),
		.frame      (frame),
		.frameValid (frameValid),
		.readBackEn (readBackEn),
		.hold       (hold),
		.hlda       (hlda),
		.sramAddr   (sramAddr),
		.sramWrData (sramWrData),
		.sramRdData (sramRdData),
		.sramWeN    (sramWeN),
		.sramOeN    (sramOeN),
		.wordOut    (wordOut),
		.wordValid  (wordValid),
		.txBusy     (txBusy)
	);

	// Read word back over the link
	txSerializer uSerializer (
		.iCLK      (iCLK),
		.iRST_n    (iRST_n),
		.wordOut   (wordOut),
		.wordValid (wordValid),
		.txData    (txData),
		.txStart   (txStart),
		.txDone    (txDone),
		.txBusy    (txBusy)
	);

endmodule

`default_nettype wire

// ==== cmdBridge_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmdBridge_assert (
	input wire logic         iCLK,
	input wire logic         iRST_n,
	input wire logic         hold,
	input wire logic         hlda,
	input wire logic         sramWeN,
	input wire logic         sramOeN,
	input wire logic         txStart,
	input wire logic         txDone,
	input wire cmdPkg::byteT txData
);

	//////////////////////////////
	// SRAM bus
	//////////////////////////////

	// WE and OE never together
	noOverlap: assert property (@(posedge iCLK) disable iff (!iRST_n)
		!(!sramWeN && !sramOeN))
		else $error("SRAM WE and OE low in the same cycle");

	// Strobe only while the bus is granted
	strobeGranted: assert property (@(posedge iCLK) disable iff (!iRST_n)
		(!sramWeN || !sramOeN) |-> (hold && hlda))
		else $error("SRAM strobe without hold and hlda");

	// Write pulse one cycle, read pulse two
	weWidth: assert property (@(posedge iCLK) disable iff (!iRST_n)
		$fell(sramWeN) |=> sramWeN)
		else $error("WE strobe not exactly one cycle");
	oeWidth: assert property (@(posedge iCLK) disable iff (!iRST_n)
		$fell(sramOeN) |=> !sramOeN ##1 sramOeN)
		else $error("OE strobe not exactly two cycles");

	// Quiet bus and link coming out of reset
	resetQuiet: assert property (@(posedge iCLK)
		!iRST_n |=> (!hold && !txStart))
		else $error("hold or txStart active after reset");

	//////////////////////////////
	// Transmit link
	//////////////////////////////

	// Start held with data steady until done
	startHeld: assert property (@(posedge iCLK) disable iff (!iRST_n)
		(txStart && !txDone) |=> (txStart && $stable(txData)))
		else $error("txStart or txData changed before txDone");

	// Start released right after done
	startReleased: assert property (@(posedge iCLK) disable iff (!iRST_n)
		(txStart && txDone) |=> !txStart)
		else $error("txStart still high after txDone");

endmodule

bind cmdBridgeTop cmdBridge_assert uAssert (
	.iCLK    (iCLK),
	.iRST_n  (iRST_n),
	.hold    (hold),
	.hlda    (hlda),
	.sramWeN (sramWeN),
	.sramOeN (sramOeN),
	.txStart (txStart),
	.txDone  (txDone),
	.txData  (txData)
);

`default_nettype wire

// ==== cmdPkg.sv ====
`default_nettype none

package cmdPkg;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	// One byte of the host link
	typedef logic [7:0] byteT;

	// SRAM word address over 256K words
	typedef logic [17:0] sramAddrT;

	// SRAM data word
	typedef logic [15:0] sramDataT;

	// Address field as carried in a frame
	typedef logic [23:0] cmdAddrT;

	//////////////////////////////
	// Command frame
	//////////////////////////////

	// First received byte lands in action
	typedef struct packed {
		byteT     action;
		byteT     target;
		cmdAddrT  addr;
		sramDataT data;
		byteT     mode;
	} cmdFrameT;

	// SRAM sequencer states
	typedef enum logic [2:0] {
		IDLE,
		HOLDREQ,
		ACCESS,
		LATCH,
		WAITTX
	} seqStateT;

endpackage

`default_nettype wire

// ==== cmd_macros.svh ====
`ifndef CMD_MACROS_SVH
`define CMD_MACROS_SVH

//////////////////////////////
// Action byte codes
//////////////////////////////
`define ACT_SETUP 8'h61
`define ACT_WRITE 8'h83
`define ACT_READ 8'h94

//////////////////////////////
// Target byte codes
//////////////////////////////
// External SRAM behind the hold bus
`define TGT_SRAM 8'h2A
// Bridge setup registers
`define TGT_SETREG 8'h4B

//////////////////////////////
// Mode byte codes
//////////////////////////////
`define MODE_NORMAL 8'hAA
`define MODE_OUTSEL 8'h33

// Address a SETUP frame must carry
`define SETUP_KEY 24'h123456

// Bytes per command frame
`define FRAME_BYTES 8

`endif

// ==== setupRegs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cmd_macros.svh"

module setupRegs (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  cmdPkg::cmdFrameT frame,
	input  logic             frameValid,
	output logic             readBackEn
);
	import cmdPkg::*;

	// Output select code in the low data byte
	byteT selCode;
	// Frame addressed to the setup registers
	logic isSetup;
	// Key matches
	logic keyOk;

	//////////////////////////////
	// SETUP decode
	//////////////////////////////

	assign selCode = frame.data[7:0];

	assign isSetup = frameValid &&
		(frame.target == `TGT_SETREG) &&
		(frame.action == `ACT_SETUP) &&
		(frame.mode == `MODE_OUTSEL);

	// Wrong key leaves everything as it was
	assign keyOk = (frame.addr == `SETUP_KEY);

	// Read-back only when SRAM is the selected source
	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
			readBackEn <= 1'b0;
		else if (isSetup && keyOk)
			readBackEn <= (selCode == `TGT_SRAM);
	end

endmodule

`default_nettype wire

// ==== sramSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cmd_macros.svh"

module sramSequencer (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  cmdPkg::cmdFrameT frame,
	input  logic             frameValid,
	input  logic             readBackEn,
	output logic             hold,
	input  logic             hlda,
	output cmdPkg::sramAddrT sramAddr,
	output cmdPkg::sramDataT sramWrData,
	input  cmdPkg::sramDataT sramRdData,
	output logic             sramWeN,
	output logic             sramOeN,
	output cmdPkg::sramDataT wordOut,
	output logic             wordValid,
	input  logic             txBusy
);
	import cmdPkg::*;

	seqStateT state;

	// Frame parked while the serializer is busy
	cmdFrameT pendFrame;
	logic     pendValid;

	// Command picked for the next access
	cmdFrameT candFrame;
	logic     candValid;

	// Incoming frame is an SRAM access
	logic frameOk;
	// Leave IDLE this cycle
	logic launch;
	// Current access is a read
	logic opRead;

	//////////////////////////////
	// Command select
	//////////////////////////////

	assign frameOk = frameValid &&
		(frame.target == `TGT_SRAM) &&
		(frame.mode == `MODE_NORMAL) &&
		((frame.action == `ACT_READ) || (frame.action == `ACT_WRITE));

	// Fresh frame wins over the parked one
	assign candFrame = frameOk ? frame : pendFrame;
	assign candValid = frameOk || pendValid;
	assign launch = (state == IDLE) && candValid && !txBusy;

	// Address, data and read word
	always_ff @(posedge iCLK)
	begin
		if ((state == IDLE) && frameOk)
			pendFrame <= frame;
		if (launch)
		begin
			// Upper address bits are ignored
			sramAddr <= candFrame.addr[17:0];
			sramWrData <= candFrame.data;
			opRead <= (candFrame.action == `ACT_READ);
		end
		// Second OE cycle
		if (state == LATCH)
			wordOut <= sramRdData;
	end

	//////////////////////////////
	// Bus FSM
	//////////////////////////////

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			state <= IDLE;
			pendValid <= 1'b0;
			hold <= 1'b0;
			sramWeN <= 1'b1;
			sramOeN <= 1'b1;
			wordValid <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (launch)
					begin
						hold <= 1'b1;
						pendValid <= 1'b0;
						state <= HOLDREQ;
					end
					// Serializer busy so park it
					else if (frameOk)
						pendValid <= 1'b1;
				end
				HOLDREQ:
				begin
					// Bus is ours once hlda shows up
					if (hlda)
					begin
						if (opRead)
							sramOeN <= 1'b0;
						else
							sramWeN <= 1'b0;
						state <= ACCESS;
					end
				end
				ACCESS:
				begin
					if (opRead)
						state <= LATCH;
					else
					begin
						// Single-cycle write strobe done
						sramWeN <= 1'b1;
						hold <= 1'b0;
						state <= IDLE;
					end
				end
				LATCH:
				begin
					sramOeN <= 1'b1;
					hold <= 1'b0;
					// Word goes out only with read-back on
					wordValid <= readBackEn;
					state <= WAITTX;
				end
				WAITTX:
				begin
					wordValid <= 1'b0;
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tb_cmdBridge.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cmd_macros.svh"

module tb_cmdBridge;
	import cmdPkg::*;

	logic     iCLK;
	logic     iRST_n;
	byteT     rxData;
	logic     rxReady;
	byteT     txData;
	logic     txStart;
	logic     txDone;
	logic     hold;
	logic     hlda;
	sramAddrT sramAddr;
	sramDataT sramWrData;
	logic     sramWeN;
	logic     sramOeN;
	sramDataT sramRdData;

	// External SRAM and the model's own copy
	sramDataT sramMem [0:262143];
	sramDataT refMem [0:262143];
	logic refReadBack;
	logic [31:0] lcgState;
	// Per-command delays for the bus models
	int hldaDelay = 0;
	int doneDelay = 0;
	// Bytes taken off the transmit link
	byteT rxBytes [$];
	// Strobe monitor counts
	int weCycles = 0;
	int oeCycles = 0;
	int badStrobes = 0;
	// Addresses reused so reads hit earlier writes
	sramAddrT addrPool [0:7];

	cmdBridgeTop dut (.*);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	//////////////////////////////
	// Bus models
	//////////////////////////////

	// Async read and a write while WE is low
	assign sramRdData = sramMem[sramAddr];
	always @(posedge iCLK)
	begin
		if (!sramWeN)
			sramMem[sramAddr] <= sramWrData;
	end

	// Grant after hldaDelay cycles and drop with hold
	initial
	begin : hldaModel
		int cnt;
		hlda = 1'b0;
		cnt = 0;
		forever
		begin
			@(posedge iCLK);
			#1;
			if (!hold)
			begin
				hlda = 1'b0;
				cnt = 0;
			end
			else if (cnt >= hldaDelay)
				hlda = 1'b1;
			else
				cnt++;
		end
	end

	// Link partner gives one done pulse per start
	initial
	begin : txLinkModel
		int cnt;
		txDone = 1'b0;
		cnt = 0;
		forever
		begin
			@(posedge iCLK);
			#1;
			txDone = 1'b0;
			if (!txStart)
				cnt = 0;
			else if (cnt >= doneDelay)
			begin
				txDone = 1'b1;
				rxBytes.push_back(txData);
				cnt = 0;
			end
			else
				cnt++;
		end
	end

	// Mid-cycle view of the strobes
	always @(negedge iCLK)
	begin
		if (!sramWeN)
			weCycles++;
		if (!sramOeN)
			oeCycles++;
		if ((!sramWeN || !sramOeN) && !(hold && hlda))
			badStrobes++;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic endFailed();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			endFailed();
		end
	endtask

	task automatic giveUp(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		endFailed();
	endtask

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Low LCG bits cycle fast so only upper bits are used
	function automatic int randBelow(input int n);
		return int'((lcgNext() >> 8) % n);
	endfunction

	// Every address bit reaches the word
	function automatic sramDataT fillWord(input sramAddrT a);
		return a[15:0] ^ {a[17:16], a[17:16], 12'h5c3};
	endfunction

	// Pool address with junk in the ignored upper bits
	function automatic cmdAddrT poolAddr();
		return {6'(lcgNext() >> 26), addrPool[randBelow(8)]};
	endfunction

	function automatic cmdFrameT makeFrame(input byteT act, input byteT tgt,
		input cmdAddrT addr, input sramDataT data, input byteT mode);
		return {act, tgt, addr, data, mode};
	endfunction

	// Bad action, bad target or non-NORMAL mode
	function automatic cmdFrameT badFrame();
		cmdFrameT f;
		int kind;
		f = makeFrame(`ACT_WRITE, `TGT_SRAM, poolAddr(), sramDataT'(lcgNext() >> 8),
			`MODE_NORMAL);
		kind = randBelow(3);
		if (kind == 0)
		begin
			f.action = byteT'(lcgNext() >> 12);
			if (f.action inside {`ACT_READ, `ACT_WRITE, `ACT_SETUP})
				f.action ^= 8'h01;
		end
		else if (kind == 1)
		begin
			f.target = byteT'(lcgNext() >> 12);
			if (f.target inside {`TGT_SRAM, `TGT_SETREG})
				f.target ^= 8'h01;
		end
		else
		begin
			f.mode = byteT'(lcgNext() >> 12);
			if (f.mode == `MODE_NORMAL)
				f.mode ^= 8'h01;
		end
		return f;
	endfunction

	// Action byte first with random gaps between bytes
	task automatic sendFrame(input cmdFrameT f);
		logic [63:0] bits;
		bits = f;
		for (int i = 0; i < `FRAME_BYTES; i++)
		begin
			repeat (randBelow(3))
				@(posedge iCLK);
			@(posedge iCLK);
			#1;
			rxData = bits[63 - 8 * i -: 8];
			rxReady = 1'b1;
			@(posedge iCLK);
			#1;
			rxReady = 1'b0;
		end
	endtask

	task automatic waitHold(input logic level);
		int n;
		n = 0;
		while (hold !== level)
		begin
			if (n == 40)
				giveUp(level ? "hold to rise" : "hold to fall");
			@(negedge iCLK);
			n++;
		end
	endtask

	task automatic waitStrobe();
		int n;
		n = 0;
		while (sramWeN && sramOeN)
		begin
			if (n == 40)
				giveUp("an SRAM strobe");
			@(negedge iCLK);
			n++;
		end
	endtask

	task automatic waitBytes(input int count);
		int n;
		n = 0;
		while (rxBytes.size() < count)
		begin
			if (n == 60)
				giveUp("read-back bytes on the transmit link");
			@(negedge iCLK);
			n++;
		end
	endtask

	//////////////////////////////
	// One frame against the model
	//////////////////////////////

	task automatic runFrame(input cmdFrameT f);
		logic legal;
		logic access;
		logic isRead;
		logic setup;
		int we0;
		int oe0;
		int expBytes;
		sramAddrT a;
		legal = (f.action inside {`ACT_READ, `ACT_WRITE, `ACT_SETUP}) &&
			(f.target inside {`TGT_SRAM, `TGT_SETREG});
		access = legal && (f.target == `TGT_SRAM) && (f.mode == `MODE_NORMAL) &&
			(f.action inside {`ACT_READ, `ACT_WRITE});
		isRead = (f.action == `ACT_READ);
		setup = legal && (f.target == `TGT_SETREG) && (f.action == `ACT_SETUP) &&
			(f.mode == `MODE_OUTSEL) && (f.addr == `SETUP_KEY);
		// Only 18 address bits reach the SRAM
		a = f.addr[17:0];
		expBytes = (access && isRead && refReadBack) ? 2 : 0;
		hldaDelay = randBelow(6);
		doneDelay = randBelow(4);
		we0 = weCycles;
		oe0 = oeCycles;
		rxBytes.delete();
		sendFrame(f);
		if (access)
		begin
			waitHold(1'b1);
			waitStrobe();
			compareValue(sramAddr, a, "SRAM address at strobe");
			compareValue(hlda, 1'b1, "hlda at strobe");
			if (!isRead)
			begin
				compareValue(sramWrData, f.data, "SRAM write data");
				refMem[a] = f.data;
			end
			waitHold(1'b0);
		end
		if (expBytes == 2)
		begin
			waitBytes(2);
			compareValue(rxBytes[0], refMem[a][7:0], "read-back low byte");
			compareValue(rxBytes[1], refMem[a][15:8], "read-back high byte");
		end
		// Nothing further may appear in a quiet stretch
		repeat (12)
			@(negedge iCLK);
		compareValue(rxBytes.size(), expBytes, "bytes on the transmit link");
		compareValue(weCycles - we0, (access && !isRead) ? 1 : 0, "WE strobe cycles");
		compareValue(oeCycles - oe0, (access && isRead) ? 2 : 0, "OE strobe cycles");
		compareValue(badStrobes, 0, "strobes outside hold and hlda");
		if (setup)
			refReadBack = (f.data[7:0] == `TGT_SRAM);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		lcgState = 32'hd7f7ca71;
		refReadBack = 1'b0;
		rxData = '0;
		rxReady = 1'b0;
		iRST_n = 1'b0;
		for (int k = 0; k < 262144; k++)
		begin
			sramMem[k] = fillWord(18'(k));
			refMem[k] = sramMem[k];
		end
		for (int k = 0; k < 8; k++)
			addrPool[k] = sramAddrT'(lcgNext() >> 9);
		repeat (3)
			@(posedge iCLK);
		#1;
		iRST_n = 1'b1;

		// Read-back is off by default so only the strobe shows
		runFrame(makeFrame(`ACT_READ, `TGT_SRAM, poolAddr(), 16'h0, `MODE_NORMAL));
		// Enable, wrong key, disable, enable again
		runFrame(makeFrame(`ACT_SETUP, `TGT_SETREG, `SETUP_KEY, {8'h00, `TGT_SRAM},
			`MODE_OUTSEL));
		runFrame(makeFrame(`ACT_READ, `TGT_SRAM, poolAddr(), 16'h0, `MODE_NORMAL));
		runFrame(makeFrame(`ACT_SETUP, `TGT_SETREG, `SETUP_KEY ^ 24'h000100, 16'h0055,
			`MODE_OUTSEL));
		runFrame(makeFrame(`ACT_READ, `TGT_SRAM, poolAddr(), 16'h0, `MODE_NORMAL));
		runFrame(makeFrame(`ACT_SETUP, `TGT_SETREG, `SETUP_KEY, 16'h0055, `MODE_OUTSEL));
		runFrame(makeFrame(`ACT_READ, `TGT_SRAM, poolAddr(), 16'h0, `MODE_NORMAL));
		runFrame(makeFrame(`ACT_SETUP, `TGT_SETREG, `SETUP_KEY, {8'h00, `TGT_SRAM},
			`MODE_OUTSEL));

		// Random mix of writes, reads and bad frames
		for (int i = 0; i < 120; i++)
		begin
			case (randBelow(10))
				0, 1, 2:
					runFrame(makeFrame(`ACT_WRITE, `TGT_SRAM, poolAddr(),
						sramDataT'(lcgNext() >> 8), `MODE_NORMAL));
				3, 4, 5:
					runFrame(makeFrame(`ACT_READ, `TGT_SRAM, poolAddr(), 16'h0,
						`MODE_NORMAL));
				6:
					runFrame(makeFrame(`ACT_READ, `TGT_SRAM, cmdAddrT'(lcgNext() >> 8),
						16'h0, `MODE_NORMAL));
				7:
					runFrame(makeFrame(`ACT_WRITE, `TGT_SRAM, cmdAddrT'(lcgNext() >> 8),
						sramDataT'(lcgNext() >> 8), `MODE_NORMAL));
				default:
					runFrame(badFrame());
			endcase
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== txSerializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module txSerializer (
	input  logic             iCLK,
	input  logic             iRST_n,
	input  cmdPkg::sramDataT wordOut,
	input  logic             wordValid,
	output cmdPkg::byteT     txData,
	output logic             txStart,
	input  logic             txDone,
	output logic             txBusy
);
	import cmdPkg::*;

	// High byte kept for the second transfer
	byteT hiByte;
	// Exchange in progress
	logic busyReg;
	// Byte in flight is the high one
	logic sendHi;

	//////////////////////////////
	// Byte sequencing
	//////////////////////////////

	// Low byte first, then high byte
	always_ff @(posedge iCLK)
	begin
		if (!busyReg && wordValid)
		begin
			txData <= wordOut[7:0];
			hiByte <= wordOut[15:8];
		end
		else if (busyReg && !txStart)
			txData <= hiByte;
	end

	always_ff @(posedge iCLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			busyReg <= 1'b0;
			txStart <= 1'b0;
			sendHi <= 1'b0;
		end
		else if (!busyReg)
		begin
			if (wordValid)
			begin
				busyReg <= 1'b1;
				txStart <= 1'b1;
				sendHi <= 1'b0;
			end
		end
		else if (txStart)
		begin
			// Drop start the cycle after done
			if (txDone)
			begin
				txStart <= 1'b0;
				if (sendHi)
					busyReg <= 1'b0;
				else
					sendHi <= 1'b1;
			end
		end
		else
		begin
			// One idle cycle between the two bytes
			txStart <= 1'b1;
		end
	end

	// Busy already in the wordValid cycle
	assign txBusy = busyReg || wordValid;

endmodule

`default_nettype wire
